/* smartnic_pkg.sv */
package smartnic_pkg;

    // ======================================================================
    // Port sizing
    // ======================================================================
    localparam int NUM_CMAC = 2;

    // One MAC-side and one host-side port per CMAC
    localparam int NUM_PORTS = 2 * NUM_CMAC;

    // Bytes per stream beat
    localparam int DATA_BYTE_WID = 8;

    // ======================================================================
    // Stream types
    // ======================================================================
    // Also the tdest encoding and the index order of every port array
    typedef enum logic [1:0] {
        PORT_CMAC0 = 2'd0,
        PORT_CMAC1 = 2'd1,
        PORT_HOST0 = 2'd2,
        PORT_HOST1 = 2'd3
    } port_t;

    // One stream beat without its tvalid and tready
    typedef struct packed {
        logic [DATA_BYTE_WID*8-1:0] tdata;
        logic [DATA_BYTE_WID-1:0]   tkeep;
        logic                       tlast;
        port_t                      tdest;
        logic                       tuser_err;
    } axis_beat_t;

endpackage : smartnic_pkg

/* smartnic_reg_pkg.sv */
package smartnic_reg_pkg;

    // ======================================================================
    // Register map
    // ======================================================================
    // Packet counters sit 4 bytes apart, in egress port order
    typedef enum logic [7:0] {
        REG_PORT_ENABLE   = 8'h00,
        REG_PKT_CNT_CMAC0 = 8'h10,
        REG_PKT_CNT_CMAC1 = 8'h14,
        REG_PKT_CNT_HOST0 = 8'h18,
        REG_PKT_CNT_HOST1 = 8'h1C,
        REG_DROP_CNT      = 8'h20
    } reg_addr_e;

    // ======================================================================
    // Reset values
    // ======================================================================
    // Every ingress port starts enabled
    localparam logic [smartnic_pkg::NUM_PORTS-1:0] PORT_ENABLE_RESET = '1;

endpackage : smartnic_reg_pkg

/* smartnic_ingress_filter.sv */
`timescale 1ns/1ns

module smartnic_ingress_filter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     port_enable,
    input  smartnic_pkg::axis_beat_t s_beat,
    input  logic                     s_tvalid,
    output logic                     s_tready,
    output smartnic_pkg::axis_beat_t m_beat,
    output logic                     m_tvalid,
    input  logic                     m_tready,
    output logic                     drop_pkt
);

    typedef enum logic [1:0] {
        FILT_IDLE,
        FILT_PASS,
        FILT_DROP
    } filt_state_e;

    filt_state_e state;
    filt_state_e state_nxt;
    logic        pass_now;
    logic        xfer;

    // Between packets the enable bit decides, inside one the state does
    always_comb begin
        case (state)
            FILT_PASS: pass_now = 1'b1;
            FILT_DROP: pass_now = 1'b0;
            default:   pass_now = port_enable;
        endcase
    end

    // Straight pass-through when passing
    assign m_beat   = s_beat;
    assign m_tvalid = s_tvalid && pass_now;

    // Dropped beats are swallowed at one per cycle
    assign s_tready = pass_now ? m_tready : 1'b1;

    assign xfer     = s_tvalid && s_tready;
    assign drop_pkt = xfer && !pass_now && s_beat.tlast;

    // A single-beat packet never leaves idle
    always_comb begin
        state_nxt = state;
        if (xfer) begin
            if (s_beat.tlast) begin
                state_nxt = FILT_IDLE;
            end else if (state == FILT_IDLE) begin
                state_nxt = pass_now ? FILT_PASS : FILT_DROP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FILT_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule : smartnic_ingress_filter

/* smartnic_egress_arb.sv */
`timescale 1ns/1ns

module smartnic_egress_arb (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [smartnic_pkg::NUM_PORTS-1:0]   req,
    input  smartnic_pkg::axis_beat_t             in_beat [smartnic_pkg::NUM_PORTS],
    output logic [smartnic_pkg::NUM_PORTS-1:0]   grant,
    output smartnic_pkg::axis_beat_t             m_beat,
    output logic                                 m_tvalid,
    input  logic                                 m_tready,
    output logic                                 pkt_done
);
    import smartnic_pkg::*;

    localparam int IDX_WID = $clog2(NUM_PORTS);

    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_e;

    arb_state_e         state;
    logic [IDX_WID-1:0] rr_ptr;
    logic [IDX_WID-1:0] lock_idx;
    logic [IDX_WID-1:0] rr_idx;
    logic [IDX_WID-1:0] cand;
    logic [IDX_WID-1:0] sel_idx;
    logic               rr_found;
    logic               xfer;

    // ======================================================================
    // Round-robin search, starting at the pointer
    // ======================================================================
    always_comb begin
        rr_found = 1'b0;
        rr_idx   = rr_ptr;
        cand     = rr_ptr;
        for (int k = 0; k < NUM_PORTS; k++) begin
            cand = rr_ptr + IDX_WID'(k);
            if (!rr_found && req[cand]) begin
                rr_found = 1'b1;
                rr_idx   = cand;
            end
        end
    end

    // Locked grant ignores every other request
    assign sel_idx = (state == ARB_LOCKED) ? lock_idx : rr_idx;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            grant[i] = (state == ARB_LOCKED || rr_found) && (sel_idx == IDX_WID'(i));
        end
    end

    // When idle with no request, req[rr_ptr] is low so tvalid stays low
    assign m_beat   = in_beat[sel_idx];
    assign m_tvalid = req[sel_idx];
    assign xfer     = m_tvalid && m_tready;
    assign pkt_done = xfer && m_beat.tlast;

    // ======================================================================
    // Lock on the first beat, release and rotate on tlast
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ARB_IDLE;
            rr_ptr   <= '0;
            lock_idx <= '0;
        end else if (xfer) begin
            if (m_beat.tlast) begin
                state  <= ARB_IDLE;
                rr_ptr <= sel_idx + 1'b1;
            end else begin
                state    <= ARB_LOCKED;
                lock_idx <= sel_idx;
            end
        end
    end

endmodule : smartnic_egress_arb

/* smartnic_switch.sv */
`timescale 1ns/1ns

module smartnic_switch (
    input  logic                               clk,
    input  logic                               rst_n,
    input  smartnic_pkg::axis_beat_t           in_beat [smartnic_pkg::NUM_PORTS],
    input  logic [smartnic_pkg::NUM_PORTS-1:0] in_tvalid,
    output logic [smartnic_pkg::NUM_PORTS-1:0] in_tready,
    output smartnic_pkg::axis_beat_t           out_beat [smartnic_pkg::NUM_PORTS],
    output logic [smartnic_pkg::NUM_PORTS-1:0] out_tvalid,
    input  logic [smartnic_pkg::NUM_PORTS-1:0] out_tready,
    output logic [smartnic_pkg::NUM_PORTS-1:0] egress_pkt_done
);
    import smartnic_pkg::*;

    // Indexed [egress][ingress]
    logic [NUM_PORTS-1:0] req   [NUM_PORTS];
    logic [NUM_PORTS-1:0] grant [NUM_PORTS];

    // Each valid beat requests exactly one egress by its tdest
    always_comb begin
        for (int e = 0; e < NUM_PORTS; e++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                req[e][i] = in_tvalid[i] && (in_beat[i].tdest == port_t'(e));
            end
        end
    end

    // Ready back from whichever egress grants the ingress
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_tready[i] = 1'b0;
            for (int e = 0; e < NUM_PORTS; e++) begin
                in_tready[i] = in_tready[i] | (grant[e][i] & out_tready[e]);
            end
        end
    end

    // ======================================================================
    // One arbiter per egress
    // ======================================================================
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_egress
        smartnic_egress_arb i_egress_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .req      (req[g]),
            .in_beat  (in_beat),
            .grant    (grant[g]),
            .m_beat   (out_beat[g]),
            .m_tvalid (out_tvalid[g]),
            .m_tready (out_tready[g]),
            .pkt_done (egress_pkt_done[g])
        );
    end : g_egress

endmodule : smartnic_switch

/* smartnic_reg_blk.sv */
`timescale 1ns/1ns

module smartnic_reg_blk #(
    parameter int CNT_WID = 32
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               reg_wr,
    input  logic                               reg_rd,
    input  logic [7:0]                         reg_addr,
    input  logic [31:0]                        reg_wdata,
    output logic [31:0]                        reg_rdata,
    output logic [smartnic_pkg::NUM_PORTS-1:0] port_enable,
    input  logic [smartnic_pkg::NUM_PORTS-1:0] egress_pkt_done,
    input  logic [smartnic_pkg::NUM_PORTS-1:0] drop_pkt
);
    import smartnic_pkg::*;
    import smartnic_reg_pkg::*;

    // Counter addresses in egress port order
    localparam reg_addr_e PKT_CNT_ADDR [NUM_PORTS] = '{
        REG_PKT_CNT_CMAC0,
        REG_PKT_CNT_CMAC1,
        REG_PKT_CNT_HOST0,
        REG_PKT_CNT_HOST1
    };

    reg_addr_e                      addr;
    logic [CNT_WID-1:0]             pkt_cnt [NUM_PORTS];
    logic [CNT_WID-1:0]             drop_cnt;
    logic [$clog2(NUM_PORTS+1)-1:0] drop_sum;

    assign addr = reg_addr_e'(reg_addr);

    // Several ports may finish a drop in the same cycle
    always_comb begin
        drop_sum = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            drop_sum = drop_sum + drop_pkt[i];
        end
    end

    // ======================================================================
    // Enable register and counters
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            port_enable <= PORT_ENABLE_RESET;
            drop_cnt    <= '0;
            for (int e = 0; e < NUM_PORTS; e++) begin
                pkt_cnt[e] <= '0;
            end
        end else begin
            if (reg_wr && addr == REG_PORT_ENABLE) begin
                port_enable <= reg_wdata[NUM_PORTS-1:0];
            end
            // Write clear beats the increment
            for (int e = 0; e < NUM_PORTS; e++) begin
                if (reg_wr && addr == PKT_CNT_ADDR[e]) begin
                    pkt_cnt[e] <= '0;
                end else if (egress_pkt_done[e]) begin
                    pkt_cnt[e] <= pkt_cnt[e] + 1'b1;
                end
            end
            if (reg_wr && addr == REG_DROP_CNT) begin
                drop_cnt <= '0;
            end else begin
                drop_cnt <= drop_cnt + CNT_WID'(drop_sum);
            end
        end
    end

    // Read data holds until the next read strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            case (addr)
                REG_PORT_ENABLE:   reg_rdata <= 32'(port_enable);
                REG_PKT_CNT_CMAC0: reg_rdata <= 32'(pkt_cnt[PORT_CMAC0]);
                REG_PKT_CNT_CMAC1: reg_rdata <= 32'(pkt_cnt[PORT_CMAC1]);
                REG_PKT_CNT_HOST0: reg_rdata <= 32'(pkt_cnt[PORT_HOST0]);
                REG_PKT_CNT_HOST1: reg_rdata <= 32'(pkt_cnt[PORT_HOST1]);
                REG_DROP_CNT:      reg_rdata <= 32'(drop_cnt);
                default:           reg_rdata <= '0;
            endcase
        end
    end

endmodule : smartnic_reg_blk

/* smartnic_322mhz.sv */
`timescale 1ns/1ns

module smartnic_322mhz #(
    parameter int CNT_WID = 32
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  smartnic_pkg::axis_beat_t          cmac_rx_beat [smartnic_pkg::NUM_CMAC],
    input  logic [smartnic_pkg::NUM_CMAC-1:0] cmac_rx_tvalid,
    output logic [smartnic_pkg::NUM_CMAC-1:0] cmac_rx_tready,
    input  smartnic_pkg::axis_beat_t          adpt_tx_beat [smartnic_pkg::NUM_CMAC],
    input  logic [smartnic_pkg::NUM_CMAC-1:0] adpt_tx_tvalid,
    output logic [smartnic_pkg::NUM_CMAC-1:0] adpt_tx_tready,
    output smartnic_pkg::axis_beat_t          cmac_tx_beat [smartnic_pkg::NUM_CMAC],
    output logic [smartnic_pkg::NUM_CMAC-1:0] cmac_tx_tvalid,
    input  logic [smartnic_pkg::NUM_CMAC-1:0] cmac_tx_tready,
    output smartnic_pkg::axis_beat_t          adpt_rx_beat [smartnic_pkg::NUM_CMAC],
    output logic [smartnic_pkg::NUM_CMAC-1:0] adpt_rx_tvalid,
    input  logic [smartnic_pkg::NUM_CMAC-1:0] adpt_rx_tready,
    input  logic                              reg_wr,
    input  logic                              reg_rd,
    input  logic [7:0]                        reg_addr,
    input  logic [31:0]                       reg_wdata,
    output logic [31:0]                       reg_rdata
);
    import smartnic_pkg::*;

    axis_beat_t           ing_beat  [NUM_PORTS];
    logic [NUM_PORTS-1:0] ing_tvalid;
    logic [NUM_PORTS-1:0] ing_tready;
    axis_beat_t           filt_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] filt_tvalid;
    logic [NUM_PORTS-1:0] filt_tready;
    axis_beat_t           egr_beat  [NUM_PORTS];
    logic [NUM_PORTS-1:0] egr_tvalid;
    logic [NUM_PORTS-1:0] egr_tready;
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] egress_pkt_done;
    logic [NUM_PORTS-1:0] drop_pkt;

    // ======================================================================
    // MAC ports first, host ports after them, as in port_t
    // ======================================================================
    for (genvar g = 0; g < NUM_CMAC; g++) begin : g_port_map
        assign ing_beat[g]            = cmac_rx_beat[g];
        assign ing_beat[g+NUM_CMAC]   = adpt_tx_beat[g];
        assign ing_tvalid[g]          = cmac_rx_tvalid[g];
        assign ing_tvalid[g+NUM_CMAC] = adpt_tx_tvalid[g];
        assign cmac_rx_tready[g]      = ing_tready[g];
        assign adpt_tx_tready[g]      = ing_tready[g+NUM_CMAC];

        assign cmac_tx_beat[g]        = egr_beat[g];
        assign adpt_rx_beat[g]        = egr_beat[g+NUM_CMAC];
        assign cmac_tx_tvalid[g]      = egr_tvalid[g];
        assign adpt_rx_tvalid[g]      = egr_tvalid[g+NUM_CMAC];
        assign egr_tready[g]          = cmac_tx_tready[g];
        assign egr_tready[g+NUM_CMAC] = adpt_rx_tready[g];
    end : g_port_map

    // Enable gate per ingress
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_ingress
        smartnic_ingress_filter i_ingress_filter (
            .clk         (clk),
            .rst_n       (rst_n),
            .port_enable (port_enable[g]),
            .s_beat      (ing_beat[g]),
            .s_tvalid    (ing_tvalid[g]),
            .s_tready    (ing_tready[g]),
            .m_beat      (filt_beat[g]),
            .m_tvalid    (filt_tvalid[g]),
            .m_tready    (filt_tready[g]),
            .drop_pkt    (drop_pkt[g])
        );
    end : g_ingress

    smartnic_switch i_switch (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_beat         (filt_beat),
        .in_tvalid       (filt_tvalid),
        .in_tready       (filt_tready),
        .out_beat        (egr_beat),
        .out_tvalid      (egr_tvalid),
        .out_tready      (egr_tready),
        .egress_pkt_done (egress_pkt_done)
    );

    smartnic_reg_blk #(
        .CNT_WID (CNT_WID)
    ) i_reg_blk (
        .clk             (clk),
        .rst_n           (rst_n),
        .reg_wr          (reg_wr),
        .reg_rd          (reg_rd),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .reg_rdata       (reg_rdata),
        .port_enable     (port_enable),
        .egress_pkt_done (egress_pkt_done),
        .drop_pkt        (drop_pkt)
    );

endmodule : smartnic_322mhz

/* tb_assertions.sv */
`timescale 1ns/1ns

module tb_assertions (
    input  logic                               clk,
    input  logic                               rst_n,
    input  smartnic_pkg::axis_beat_t           ing_beat [smartnic_pkg::NUM_PORTS],
    input  logic [smartnic_pkg::NUM_PORTS-1:0] ing_tvalid,
    input  logic [smartnic_pkg::NUM_PORTS-1:0] ing_tready,
    input  smartnic_pkg::axis_beat_t           egr_beat [smartnic_pkg::NUM_PORTS],
    input  logic [smartnic_pkg::NUM_PORTS-1:0] egr_tvalid,
    input  logic [smartnic_pkg::NUM_PORTS-1:0] egr_tready
);
    import smartnic_pkg::*;

    localparam int IDX_WID = $clog2(NUM_PORTS);

    int                   fail_cnt = 0;
    logic [NUM_PORTS-1:0] in_pkt;
    logic [IDX_WID-1:0]   head_src [NUM_PORTS];
    logic [IDX_WID-1:0]   pkt_src  [NUM_PORTS];

    // Ingress that hands its beat to each egress in this cycle
    always_comb begin
        for (int e = 0; e < NUM_PORTS; e++) begin
            head_src[e] = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (ing_tvalid[i] && ing_tready[i] && ing_beat[i] == egr_beat[e]) begin
                    head_src[e] = IDX_WID'(i);
                end
            end
        end
    end

    // Granted ingress of the packet in flight, taken from its first beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt <= '0;
            for (int e = 0; e < NUM_PORTS; e++) begin
                pkt_src[e] <= '0;
            end
        end else begin
            for (int e = 0; e < NUM_PORTS; e++) begin
                if (egr_tvalid[e] && egr_tready[e]) begin
                    if (!in_pkt[e]) begin
                        pkt_src[e] <= head_src[e];
                    end
                    in_pkt[e] <= !egr_beat[e].tlast;
                end
            end
        end
    end

    // No egress offers a beat while in reset
    assert property (@(negedge clk) !rst_n |-> egr_tvalid == '0)
        else begin
            $error("egress tvalid high during reset");
            fail_cnt++;
        end

    // ======================================================================
    // Per-port stream rules
    // ======================================================================
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        assert property (@(posedge clk) disable iff (!rst_n)
            egr_tvalid[g] && !egr_tready[g] |=> egr_tvalid[g] && $stable(egr_beat[g]))
            else begin
                $error("egress %0d changed a stalled beat", g);
                fail_cnt++;
            end

        // Mid-packet beats come from the ingress that started the packet
        assert property (@(posedge clk) disable iff (!rst_n)
            egr_tvalid[g] |-> egr_beat[g].tdest == port_t'(g) &&
                (!in_pkt[g] || (ing_tvalid[pkt_src[g]] &&
                                egr_beat[g] == ing_beat[pkt_src[g]])))
            else begin
                $error("egress %0d beat is not from its granted ingress", g);
                fail_cnt++;
            end
    end : g_port

endmodule : tb_assertions

/* tb.sv */
`timescale 1ns/1ns

module tb;
    import smartnic_pkg::*;
    import smartnic_reg_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RST_CYCLES    = 5;
    localparam int CNT_WID       = 16;
    // Routing, contention at half rate, round robin, disable, counters
    localparam int TEST_CYCLES   = 16 * 6 + 2 * 12 * 6 + 12 * 3 + 40 + 30;
    localparam int MARGIN_CYCLES = 300;

    logic                 clk;
    logic                 rst_n;
    axis_beat_t           in_beat      [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    axis_beat_t           out_beat     [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_ready;
    axis_beat_t           cmac_rx_beat [NUM_CMAC];
    axis_beat_t           adpt_tx_beat [NUM_CMAC];
    axis_beat_t           cmac_tx_beat [NUM_CMAC];
    axis_beat_t           adpt_rx_beat [NUM_CMAC];
    logic                 reg_wr;
    logic                 reg_rd;
    logic [7:0]           reg_addr;
    logic [31:0]          reg_wdata;
    logic [31:0]          reg_rdata;

    // Expected beats per egress and source at index egress * NUM_PORTS + source
    axis_beat_t exp_q    [NUM_PORTS*NUM_PORTS][$];
    int         pkt_log  [NUM_PORTS][$];
    int         exp_pkts [NUM_PORTS];
    bit         in_pkt   [NUM_PORTS];
    int         cur_src  [NUM_PORTS];
    int         err_cnt;
    int         seq;
    bit         rand_ready;
    string      test_name;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Port arrays in port_t order
    for (genvar g = 0; g < NUM_CMAC; g++) begin : g_map
        assign cmac_rx_beat[g]        = in_beat[g];
        assign adpt_tx_beat[g]        = in_beat[g+NUM_CMAC];
        assign out_beat[g]            = cmac_tx_beat[g];
        assign out_beat[g+NUM_CMAC]   = adpt_rx_beat[g];
    end : g_map

    smartnic_322mhz #(
        .CNT_WID (CNT_WID)
    ) smartnic_322mhz_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmac_rx_beat   (cmac_rx_beat),
        .cmac_rx_tvalid (in_valid[1:0]),
        .cmac_rx_tready (in_ready[1:0]),
        .adpt_tx_beat   (adpt_tx_beat),
        .adpt_tx_tvalid (in_valid[3:2]),
        .adpt_tx_tready (in_ready[3:2]),
        .cmac_tx_beat   (cmac_tx_beat),
        .cmac_tx_tvalid (out_valid[1:0]),
        .cmac_tx_tready (out_ready[1:0]),
        .adpt_rx_beat   (adpt_rx_beat),
        .adpt_rx_tvalid (out_valid[3:2]),
        .adpt_rx_tready (out_ready[3:2]),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata)
    );

    bind smartnic_322mhz tb_assertions i_tb_assertions (
        .clk        (clk),
        .rst_n      (rst_n),
        .ing_beat   (ing_beat),
        .ing_tvalid (ing_tvalid),
        .ing_tready (ing_tready),
        .egr_beat   (egr_beat),
        .egr_tvalid (egr_tvalid),
        .egr_tready (egr_tready)
    );

    // ======================================================================
    // Checker and bus tasks
    // ======================================================================
    task automatic check_value(string what, logic [127:0] exp, logic [127:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic reg_write(logic [7:0] addr, logic [31:0] data);
        @(posedge clk);
        #10;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #10;
        reg_wr    = 1'b0;
    endtask

    task automatic reg_read(logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #10;
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge clk);
        #10;
        reg_rd   = 1'b0;
        data     = reg_rdata;
    endtask

    // Source id sits in tdata[63:56] so the receiver can sort beats
    task automatic send_pkts(int port, int dest, int min_len, int max_len, int count,
                             bit expect_out);
        axis_beat_t b;
        int         len;
        @(posedge clk);
        for (int n = 0; n < count; n++) begin
            len = min_len + int'($urandom % (max_len - min_len + 1));
            if (expect_out) begin
                exp_pkts[dest]++;
            end
            for (int k = 0; k < len; k++) begin
                b.tdata     = {8'(port), 24'(seq), $urandom};
                b.tkeep     = (k == len - 1) ? 8'($urandom | 1) : 8'hFF;
                b.tlast     = (k == len - 1);
                b.tdest     = port_t'(dest);
                b.tuser_err = (k == len - 1) && ($urandom % 4 == 0);
                seq++;
                if (expect_out) begin
                    exp_q[dest*NUM_PORTS+port].push_back(b);
                end
                #10;
                in_beat[port]  = b;
                in_valid[port] = 1'b1;
                @(negedge clk);
                while (!in_ready[port]) begin
                    @(negedge clk);
                end
                @(posedge clk);
            end
        end
        #10;
        in_valid[port] = 1'b0;
    endtask

    task automatic take_beat(int e, axis_beat_t b);
        int src;
        src = int'(b.tdata[57:56]);
        if (!in_pkt[e]) begin
            cur_src[e] = src;
            pkt_log[e].push_back(src);
        end
        check_value("packet source", cur_src[e], src);
        in_pkt[e] = !b.tlast;
        if (exp_q[e*NUM_PORTS+src].size() == 0) begin
            err_cnt++;
            $display("%s: unexpected beat at egress %0d from ingress %0d", test_name, e, src);
        end else begin
            check_value("beat", exp_q[e*NUM_PORTS+src].pop_front(), b);
        end
    endtask

    // Egress sinks with ready changing 10 ns after the edge
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_rx
        always @(posedge clk) begin
            #10;
            out_ready[g] = rand_ready ? 1'($urandom) : 1'b1;
        end
        always @(negedge clk) begin
            if (rst_n && out_valid[g] && out_ready[g]) begin
                take_beat(g, out_beat[g]);
            end
        end
    end : g_rx

    // ======================================================================
    // Tests
    // ======================================================================
    task automatic test_routing();
        test_name = "routing";
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int d = 0; d < NUM_PORTS; d++) begin
                send_pkts(p, d, 1, 4, 1, 1'b1);
            end
        end
    endtask

    task automatic test_contention();
        test_name  = "contention";
        rand_ready = 1'b1;
        fork
            send_pkts(0, PORT_HOST1, 2, 6, 4, 1'b1);
            send_pkts(1, PORT_HOST1, 2, 6, 4, 1'b1);
            send_pkts(2, PORT_HOST1, 2, 6, 4, 1'b1);
        join
        rand_ready = 1'b0;
    endtask

    task automatic test_round_robin();
        int start;
        test_name = "round robin";
        start     = pkt_log[PORT_CMAC1].size();
        fork
            send_pkts(0, PORT_CMAC1, 1, 3, 3, 1'b1);
            send_pkts(1, PORT_CMAC1, 1, 3, 3, 1'b1);
            send_pkts(2, PORT_CMAC1, 1, 3, 3, 1'b1);
            send_pkts(3, PORT_CMAC1, 1, 3, 3, 1'b1);
        join
        for (int k = start + 1; k < pkt_log[PORT_CMAC1].size(); k++) begin
            check_value("next source", (pkt_log[PORT_CMAC1][k-1] + 1) % NUM_PORTS,
                        pkt_log[PORT_CMAC1][k]);
        end
    endtask

    task automatic test_disable();
        logic [31:0] val;
        test_name = "port disable";
        // Enable drops while the long packet is in flight
        fork
            send_pkts(1, PORT_HOST0, 8, 8, 1, 1'b1);
            begin
                repeat (3) @(posedge clk);
                reg_write(REG_PORT_ENABLE, 32'hD);
            end
        join
        send_pkts(1, PORT_CMAC0, 1, 4, 3, 1'b0);
        reg_read(REG_DROP_CNT, val);
        check_value("drop count", 3, val);
        reg_write(REG_PORT_ENABLE, 32'hF);
    endtask

    task automatic test_counters();
        logic [31:0] val;
        test_name = "counters";
        for (int e = 0; e < NUM_PORTS; e++) begin
            reg_read(8'(REG_PKT_CNT_CMAC0 + 4 * e), val);
            check_value("packet count", exp_pkts[e], val);
        end
        // Last read left a nonzero count in reg_rdata
        reg_read(8'h44, val);
        check_value("unmapped read", 0, val);
        reg_write(REG_PKT_CNT_HOST0, 32'h1234);
        reg_read(REG_PKT_CNT_HOST0, val);
        check_value("cleared count", 0, val);
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================
    initial begin
        int asrt_cnt;
        void'($urandom(10));
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = '0;
        out_ready  = '1;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        rand_ready = 1'b0;
        err_cnt    = 0;
        seq        = 0;
        test_name  = "reset";
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_beat[p]  = '0;
            exp_pkts[p] = 0;
            in_pkt[p]   = 1'b0;
            cur_src[p]  = 0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;

        test_routing();
        test_contention();
        test_round_robin();
        test_disable();
        test_counters();

        repeat (4) @(posedge clk);
        for (int q = 0; q < NUM_PORTS * NUM_PORTS; q++) begin
            if (exp_q[q].size() != 0) begin
                err_cnt++;
                $display("%0d beats from ingress %0d never left egress %0d",
                         exp_q[q].size(), q % NUM_PORTS, q / NUM_PORTS);
            end
        end
        asrt_cnt = smartnic_322mhz_i.i_tb_assertions.fail_cnt;
        $display("Errors: %0d check, %0d assertion", err_cnt, asrt_cnt);
        if (err_cnt == 0 && asrt_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #((RST_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: tests still running after %0d cycles",
                 RST_CYCLES + TEST_CYCLES + MARGIN_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule : tb

/* smartnic_322mhz.f */
smartnic_pkg.sv
smartnic_reg_pkg.sv
smartnic_ingress_filter.sv
smartnic_egress_arb.sv
smartnic_switch.sv
smartnic_reg_blk.sv
smartnic_322mhz.sv
tb_assertions.sv
tb.sv
